//--- hdl/lsu_pkg.sv
/*
 * Load/store unit shared definitions
 * Data, tag and memory widths plus the opcode and access-size
 * encodings used across the load/store path
 */

`default_nettype none

package lsu_pkg;

    // ======================================================================
    // Datapath widths
    // ======================================================================

    // Register and memory word width
    localparam int XLEN = 32;

    // One strobe bit per byte lane
    localparam int WMASK_WIDTH = XLEN / 8;

    // Instruction tag carried from issue to write-back
    localparam int ITAG_WIDTH = 2;

    // Signed immediate on the issue port
    localparam int OFFSET_WIDTH = 12;

    // ======================================================================
    // Data memory geometry
    // ======================================================================

    // Byte address width, 1 KiB of data memory
    localparam int DTCM_AW = 10;

    // Number of XLEN-wide words
    localparam int DTCM_DEPTH = 256;

    // Word index width, upper address bits above the byte offset
    localparam int DTCM_IDX_W = $clog2(DTCM_DEPTH);

    // ======================================================================
    // Encodings
    // ======================================================================

    // Load/store opcodes seen on the issue port
    typedef enum logic [2:0] {
        LB  = 3'd0,
        LH  = 3'd1,
        LW  = 3'd2,
        LBU = 3'd3,
        LHU = 3'd4,
        SB  = 3'd5,
        SH  = 3'd6,
        SW  = 3'd7
    } lsu_op_e;

    // Access size decoded from the opcode
    typedef enum logic [1:0] {
        SIZE_B = 2'd0,
        SIZE_H = 2'd1,
        SIZE_W = 2'd2
    } lsu_size_e;

endpackage

`default_nettype wire

//--- hdl/lsu_ifc.sv
/*
 * Load/store unit internal channels
 * agu_cmd_if carries decoded accesses from the AGU to the controller,
 * dtcm_if carries memory commands and responses to the data memory
 */

`timescale 1ns/1ps
`default_nettype none

// AGU to controller command channel
interface agu_cmd_if;
    logic                                 valid;
    logic                                 ready;
    logic                                 read;
    logic [lsu_pkg::DTCM_AW-1:0]          addr;
    // Store data already replicated into its lanes
    logic [lsu_pkg::XLEN-1:0]             wdata;
    logic [lsu_pkg::WMASK_WIDTH-1:0]      wmask;
    lsu_pkg::lsu_size_e                   size;
    // Load result is sign extended
    logic                                 sign;
    logic                                 misaligned;
    logic [lsu_pkg::ITAG_WIDTH-1:0]       itag;

    modport src (
        output valid, read, addr, wdata, wmask, size, sign, misaligned, itag,
        input  ready
    );

    modport dst (
        input  valid, read, addr, wdata, wmask, size, sign, misaligned, itag,
        output ready
    );
endinterface

// Controller to data memory channel
interface dtcm_if;
    // Command half
    logic                                 cmd_valid;
    logic                                 cmd_ready;
    logic                                 cmd_read;
    logic [lsu_pkg::DTCM_AW-1:0]          cmd_addr;
    logic [lsu_pkg::XLEN-1:0]             cmd_wdata;
    logic [lsu_pkg::WMASK_WIDTH-1:0]      cmd_wmask;
    // Response half, one per command
    logic                                 rsp_valid;
    logic                                 rsp_ready;
    logic [lsu_pkg::XLEN-1:0]             rsp_rdata;

    modport master (
        output cmd_valid, cmd_read, cmd_addr, cmd_wdata, cmd_wmask, rsp_ready,
        input  cmd_ready, rsp_valid, rsp_rdata
    );

    modport slave (
        input  cmd_valid, cmd_read, cmd_addr, cmd_wdata, cmd_wmask, rsp_ready,
        output cmd_ready, rsp_valid, rsp_rdata
    );
endinterface

`default_nettype wire

//--- hdl/agu.sv
/*
 * Address generation unit
 * Forms the byte address from base plus offset, decodes the opcode,
 * builds byte strobes and lane-aligned store data, flags misalignment
 */

`timescale 1ns/1ps
`default_nettype none

module agu (
    input  logic                               clk,
    input  logic                               rst,
    input  logic                               issue_valid,
    output logic                               issue_ready,
    input  lsu_pkg::lsu_op_e                   issue_op,
    input  logic [lsu_pkg::XLEN-1:0]           issue_base,
    input  logic [lsu_pkg::OFFSET_WIDTH-1:0]   issue_offset,
    input  logic [lsu_pkg::XLEN-1:0]           issue_wdata,
    input  logic [lsu_pkg::ITAG_WIDTH-1:0]     issue_itag,
    agu_cmd_if.src                             cmd
);

    logic [lsu_pkg::XLEN-1:0]    offset_sext;
    logic [lsu_pkg::XLEN-1:0]    eff_addr;
    logic [lsu_pkg::DTCM_AW-1:0] addr;
    lsu_pkg::lsu_size_e          size;
    logic                        read;
    logic                        sign;

    // ======================================================================
    // Address
    // ======================================================================

    assign offset_sext = {{(lsu_pkg::XLEN - lsu_pkg::OFFSET_WIDTH){issue_offset[lsu_pkg::OFFSET_WIDTH-1]}},
                          issue_offset};
    assign eff_addr    = issue_base + offset_sext;
    // Upper bits dropped, address wraps within the memory window
    assign addr        = eff_addr[lsu_pkg::DTCM_AW-1:0];

    // ======================================================================
    // Opcode decode
    // ======================================================================

    always_comb begin
        read = 1'b1;
        sign = 1'b0;
        size = lsu_pkg::SIZE_W;
        case (issue_op)
            lsu_pkg::LB: begin
                size = lsu_pkg::SIZE_B;
                sign = 1'b1;
            end
            lsu_pkg::LH: begin
                size = lsu_pkg::SIZE_H;
                sign = 1'b1;
            end
            lsu_pkg::LBU: size = lsu_pkg::SIZE_B;
            lsu_pkg::LHU: size = lsu_pkg::SIZE_H;
            lsu_pkg::SB: begin
                size = lsu_pkg::SIZE_B;
                read = 1'b0;
            end
            lsu_pkg::SH: begin
                size = lsu_pkg::SIZE_H;
                read = 1'b0;
            end
            lsu_pkg::SW: read = 1'b0;
            default: size = lsu_pkg::SIZE_W;
        endcase
    end

    // ======================================================================
    // Strobes, store lanes and misalignment
    // ======================================================================

    always_comb begin
        case (size)
            lsu_pkg::SIZE_B: begin
                cmd.wmask = lsu_pkg::WMASK_WIDTH'(4'b0001 << addr[1:0]);
                // Byte copied into all four lanes
                cmd.wdata = {4{issue_wdata[7:0]}};
            end
            lsu_pkg::SIZE_H: begin
                cmd.wmask = lsu_pkg::WMASK_WIDTH'(4'b0011 << {addr[1], 1'b0});
                cmd.wdata = {2{issue_wdata[15:0]}};
            end
            default: begin
                cmd.wmask = 4'b1111;
                cmd.wdata = issue_wdata;
            end
        endcase
    end

    // Halfword needs an even address, word needs a multiple of four
    assign cmd.misaligned = ((size == lsu_pkg::SIZE_H) && addr[0]) ||
                            ((size == lsu_pkg::SIZE_W) && (addr[1:0] != 2'b00));

    assign cmd.valid = issue_valid;
    assign cmd.read  = read;
    assign cmd.addr  = addr;
    assign cmd.size  = size;
    assign cmd.sign  = sign;
    assign cmd.itag  = issue_itag;

    // Issue handshake is the command handshake
    assign issue_ready = cmd.ready;

    // Issuer keeps the request and its opcode until accepted
    a_issue_hold: assert property (@(posedge clk) disable iff (rst)
        issue_valid && !issue_ready |=> issue_valid && $stable(issue_op) && $stable(issue_itag))
        else $error("issue request changed before it was accepted");

endmodule

`default_nettype wire

//--- hdl/lsu_ctrl.sv
/*
 * Load/store controller
 * Allows one outstanding access, forwards aligned commands to the data
 * memory, holds tag and extension info, returns results on write-back
 */

`timescale 1ns/1ps
`default_nettype none

module lsu_ctrl (
    input  logic                            clk,
    input  logic                            rst,
    agu_cmd_if.dst                          cmd,
    dtcm_if.master                          mem,
    output logic                            wb_valid,
    input  logic                            wb_ready,
    output logic [lsu_pkg::XLEN-1:0]        wb_data,
    output logic [lsu_pkg::ITAG_WIDTH-1:0]  wb_itag,
    output logic                            wb_err
);

    // Stage occupancy, WAIT_ERR means the access never went to memory
    typedef enum logic [1:0] {
        IDLE     = 2'd0,
        WAIT_MEM = 2'd1,
        WAIT_ERR = 2'd2
    } state_e;

    state_e                          state_q;
    logic [lsu_pkg::ITAG_WIDTH-1:0]  itag_q;
    lsu_pkg::lsu_size_e              size_q;
    logic                            sign_q;
    logic [1:0]                      addr_lo_q;
    logic                            read_q;

    logic                            wb_hsk;
    logic                            stage_free;
    logic                            cmd_hsk;
    logic [lsu_pkg::XLEN-1:0]        rdata_shift;

    // ======================================================================
    // Accept and forward
    // ======================================================================

    assign wb_valid   = ((state_q == WAIT_MEM) && mem.rsp_valid) || (state_q == WAIT_ERR);
    assign wb_hsk     = wb_valid && wb_ready;
    // Stage can take a new access when empty or draining this cycle
    assign stage_free = (state_q == IDLE) || wb_hsk;

    // Misaligned accesses only need the stage, not the memory
    assign cmd.ready  = stage_free && (cmd.misaligned || mem.cmd_ready);
    assign cmd_hsk    = cmd.valid && cmd.ready;

    assign mem.cmd_valid = cmd.valid && stage_free && !cmd.misaligned;
    assign mem.cmd_read  = cmd.read;
    assign mem.cmd_addr  = cmd.addr;
    assign mem.cmd_wdata = cmd.wdata;
    assign mem.cmd_wmask = cmd.wmask;
    assign mem.rsp_ready = wb_ready;

    // ======================================================================
    // Tag stage
    // ======================================================================

    always_ff @(posedge clk) begin
        if (rst) begin
            state_q <= IDLE;
        end else if (cmd_hsk) begin
            state_q <= cmd.misaligned ? WAIT_ERR : WAIT_MEM;
        end else if (wb_hsk) begin
            state_q <= IDLE;
        end
    end

    // Access info captured alongside the command
    always_ff @(posedge clk) begin
        if (cmd_hsk) begin
            itag_q    <= cmd.itag;
            size_q    <= cmd.size;
            sign_q    <= cmd.sign;
            addr_lo_q <= cmd.addr[1:0];
            read_q    <= cmd.read;
        end
    end

    // ======================================================================
    // Write-back
    // ======================================================================

    // Bring the addressed lane down to bit 0
    assign rdata_shift = mem.rsp_rdata >> {addr_lo_q, 3'b000};

    always_comb begin
        wb_data = '0;
        // Stores and errors return zero
        if ((state_q == WAIT_MEM) && read_q) begin
            case (size_q)
                lsu_pkg::SIZE_B:
                    wb_data = {{(lsu_pkg::XLEN-8){sign_q & rdata_shift[7]}}, rdata_shift[7:0]};
                lsu_pkg::SIZE_H:
                    wb_data = {{(lsu_pkg::XLEN-16){sign_q & rdata_shift[15]}}, rdata_shift[15:0]};
                default:
                    wb_data = mem.rsp_rdata;
            endcase
        end
    end

    assign wb_itag = itag_q;
    assign wb_err  = (state_q == WAIT_ERR);

    // Memory only answers an access this stage sent
    a_rsp_in_wait: assert property (@(posedge clk) disable iff (rst)
        mem.rsp_valid |-> state_q == WAIT_MEM)
        else $error("memory response without an outstanding access");

    // Write-back held with its payload under back-pressure
    a_wb_hold: assert property (@(posedge clk) disable iff (rst)
        wb_valid && !wb_ready |=> wb_valid && $stable(wb_data) && $stable(wb_itag)
                                 && $stable(wb_err))
        else $error("write-back dropped or changed before wb_ready");

endmodule

`default_nettype wire

//--- hdl/dtcm.sv
/*
 * Tightly coupled data memory
 * Single-port word memory with byte-lane writes and a registered
 * one-cycle response held until the master takes it
 */

`timescale 1ns/1ps
`default_nettype none

module dtcm (
    input  logic    clk,
    input  logic    rst,
    dtcm_if.slave   bus
);

    logic [lsu_pkg::XLEN-1:0]       mem_q [lsu_pkg::DTCM_DEPTH];
    logic [lsu_pkg::DTCM_IDX_W-1:0] idx;
    logic                           cmd_hsk;
    logic                           rsp_valid_q;
    logic [lsu_pkg::XLEN-1:0]       rsp_rdata_q;

    // Word index from the byte address
    assign idx     = bus.cmd_addr[lsu_pkg::DTCM_AW-1:2];
    assign cmd_hsk = bus.cmd_valid && bus.cmd_ready;

    // Room for a new command once the held response leaves
    assign bus.cmd_ready = !rsp_valid_q || bus.rsp_ready;

    // ======================================================================
    // Storage
    // ======================================================================

    // Memory starts cleared in simulation
    initial begin
        for (int i = 0; i < lsu_pkg::DTCM_DEPTH; i++) begin
            mem_q[i] = '0;
        end
    end

    // Byte-lane writes under the strobe mask
    always_ff @(posedge clk) begin
        if (cmd_hsk && !bus.cmd_read) begin
            for (int lane = 0; lane < lsu_pkg::WMASK_WIDTH; lane++) begin
                if (bus.cmd_wmask[lane]) begin
                    mem_q[idx][lane*8 +: 8] <= bus.cmd_wdata[lane*8 +: 8];
                end
            end
        end
    end

    // ======================================================================
    // Response
    // ======================================================================

    always_ff @(posedge clk) begin
        if (rst) begin
            rsp_valid_q <= 1'b0;
        end else if (cmd_hsk) begin
            // Stores answer too and leave the read data stale
            rsp_valid_q <= 1'b1;
        end else if (bus.rsp_ready) begin
            rsp_valid_q <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (cmd_hsk && bus.cmd_read) begin
            rsp_rdata_q <= mem_q[idx];
        end
    end

    assign bus.rsp_valid = rsp_valid_q;
    assign bus.rsp_rdata = rsp_rdata_q;

    // Master offers a new command only while a held response is leaving
    a_no_overrun: assert property (@(posedge clk) disable iff (rst)
        bus.cmd_valid && rsp_valid_q |-> bus.rsp_ready)
        else $error("command offered while a response was pending");

endmodule

`default_nettype wire

//--- hdl/lsu_top.sv
/*
 * Load/store unit top level
 * Connects the AGU, the one-outstanding controller and the data memory
 * behind a plain issue port and a plain write-back port
 */

`timescale 1ns/1ps
`default_nettype none

module lsu_top (
    input  logic                               clk,
    input  logic                               rst,
    // Issue channel
    input  logic                               issue_valid,
    output logic                               issue_ready,
    input  lsu_pkg::lsu_op_e                   issue_op,
    input  logic [lsu_pkg::XLEN-1:0]           issue_base,
    input  logic [lsu_pkg::OFFSET_WIDTH-1:0]   issue_offset,
    input  logic [lsu_pkg::XLEN-1:0]           issue_wdata,
    input  logic [lsu_pkg::ITAG_WIDTH-1:0]     issue_itag,
    // Write-back channel
    output logic                               wb_valid,
    input  logic                               wb_ready,
    output logic [lsu_pkg::XLEN-1:0]           wb_data,
    output logic [lsu_pkg::ITAG_WIDTH-1:0]     wb_itag,
    output logic                               wb_err
);

    // Internal channels
    agu_cmd_if agu_cmd ();
    dtcm_if    dtcm_bus ();

    // Decode and address
    agu u_agu (
        .clk          (clk),
        .rst          (rst),
        .issue_valid  (issue_valid),
        .issue_ready  (issue_ready),
        .issue_op     (issue_op),
        .issue_base   (issue_base),
        .issue_offset (issue_offset),
        .issue_wdata  (issue_wdata),
        .issue_itag   (issue_itag),
        .cmd          (agu_cmd.src)
    );

    // Single outstanding access and write-back
    lsu_ctrl u_lsu_ctrl (
        .clk      (clk),
        .rst      (rst),
        .cmd      (agu_cmd.dst),
        .mem      (dtcm_bus.master),
        .wb_valid (wb_valid),
        .wb_ready (wb_ready),
        .wb_data  (wb_data),
        .wb_itag  (wb_itag),
        .wb_err   (wb_err)
    );

    // Data memory
    dtcm u_dtcm (
        .clk (clk),
        .rst (rst),
        .bus (dtcm_bus.slave)
    );

endmodule

`default_nettype wire

//--- bench/tb_clock.sv
/*
 * Testbench clock source
 * Free-running clock with a 100 ns period, starting low
 */

`timescale 1ns/1ps
`default_nettype none

module tb_clock (
    output logic clk
);

    // Half of the 100 ns period
    localparam int HALF_PERIOD = 50;

    initial begin
        clk = 1'b0;
        forever #(HALF_PERIOD) clk = ~clk;
    end

endmodule

`default_nettype wire

//--- bench/tb_lsu.sv
/*
 * Load/store unit testbench
 * Replays accesses from the stimulus file under random write-back
 * back-pressure and checks each write-back in issue order
 */

`timescale 1ns/1ps
`default_nettype none

module tb_lsu;

    localparam int    CLK_PERIOD = 100;
    // Sample point, well clear of both clock edges
    localparam int    SAMPLE_DLY = CLK_PERIOD / 4;
    localparam int    WAIT_LIMIT = 50;
    localparam string STIM_FILE  = "bench/lsu_stimulus.txt";

    logic                              clk;
    logic                              rst;
    logic                              issue_valid;
    logic                              issue_ready;
    lsu_pkg::lsu_op_e                  issue_op;
    logic [lsu_pkg::XLEN-1:0]          issue_base;
    logic [lsu_pkg::OFFSET_WIDTH-1:0]  issue_offset;
    logic [lsu_pkg::XLEN-1:0]          issue_wdata;
    logic [lsu_pkg::ITAG_WIDTH-1:0]    issue_itag;
    logic                              wb_valid;
    logic                              wb_ready;
    logic [lsu_pkg::XLEN-1:0]          wb_data;
    logic [lsu_pkg::ITAG_WIDTH-1:0]    wb_itag;
    logic                              wb_err;

    // Accesses as read from the file
    lsu_pkg::lsu_op_e                  stim_op[$];
    logic [lsu_pkg::XLEN-1:0]          stim_base[$];
    logic [lsu_pkg::OFFSET_WIDTH-1:0]  stim_offset[$];
    logic [lsu_pkg::XLEN-1:0]          stim_wdata[$];
    logic [lsu_pkg::ITAG_WIDTH-1:0]    stim_itag[$];
    logic [lsu_pkg::XLEN-1:0]          stim_exp_data[$];
    logic                              stim_exp_err[$];

    // Scoreboard, pushed at issue and popped at write-back
    int                                exp_idx_q[$];
    logic [lsu_pkg::XLEN-1:0]          exp_data_q[$];
    logic [lsu_pkg::ITAG_WIDTH-1:0]    exp_itag_q[$];
    logic                              exp_err_q[$];

    int                                checks;
    int                                data_errors;
    int                                itag_errors;
    int                                err_errors;
    int                                other_errors;
    logic                              timed_out;
    logic [31:0]                       lcg_state;

    tb_clock u_tb_clock (
        .clk (clk)
    );

    lsu_top u_lsu_top (
        .clk          (clk),
        .rst          (rst),
        .issue_valid  (issue_valid),
        .issue_ready  (issue_ready),
        .issue_op     (issue_op),
        .issue_base   (issue_base),
        .issue_offset (issue_offset),
        .issue_wdata  (issue_wdata),
        .issue_itag   (issue_itag),
        .wb_valid     (wb_valid),
        .wb_ready     (wb_ready),
        .wb_data      (wb_data),
        .wb_itag      (wb_itag),
        .wb_err       (wb_err)
    );

    // ======================================================================
    // Helpers
    // ======================================================================

    function automatic logic [31:0] lcg_next(input logic [31:0] state);
        return state * 32'd1664525 + 32'd1013904223;
    endfunction

    // Mnemonic to opcode, returns 0 for an unknown name
    function automatic bit op_from_name(input string name, output lsu_pkg::lsu_op_e op);
        op = lsu_pkg::LB;
        case (name)
            "LB":    op = lsu_pkg::LB;
            "LH":    op = lsu_pkg::LH;
            "LW":    op = lsu_pkg::LW;
            "LBU":   op = lsu_pkg::LBU;
            "LHU":   op = lsu_pkg::LHU;
            "SB":    op = lsu_pkg::SB;
            "SH":    op = lsu_pkg::SH;
            "SW":    op = lsu_pkg::SW;
            default: return 1'b0;
        endcase
        return 1'b1;
    endfunction

    task automatic load_stimulus();
        int                               fd;
        int                               n;
        string                            line;
        string                            name;
        lsu_pkg::lsu_op_e                 op;
        logic [lsu_pkg::XLEN-1:0]         base;
        logic [lsu_pkg::OFFSET_WIDTH-1:0] offset;
        logic [lsu_pkg::XLEN-1:0]         wdata;
        logic [lsu_pkg::ITAG_WIDTH-1:0]   itag;
        logic [lsu_pkg::XLEN-1:0]         exp_data;
        logic                             exp_err;
        fd = $fopen(STIM_FILE, "r");
        if (fd == 0) begin
            $display("Could not open the stimulus file %s", STIM_FILE);
            other_errors++;
            return;
        end
        while (!$feof(fd)) begin
            line = "";
            void'($fgets(line, fd));
            // Blank lines and comments
            if (line.len() < 2 || line.substr(0, 0) == "#") begin
                continue;
            end
            n = $sscanf(line, "%s %h %h %h %h %h %h", name, base, offset, wdata, itag,
                        exp_data, exp_err);
            if (n != 7 || !op_from_name(name, op)) begin
                $display("Malformed stimulus line: %s", line);
                other_errors++;
                continue;
            end
            stim_op.push_back(op);
            stim_base.push_back(base);
            stim_offset.push_back(offset);
            stim_wdata.push_back(wdata);
            stim_itag.push_back(itag);
            stim_exp_data.push_back(exp_data);
            stim_exp_err.push_back(exp_err);
        end
        $fclose(fd);
    endtask

    // ======================================================================
    // Compare tasks
    // ======================================================================

    task automatic check_data(input logic [lsu_pkg::XLEN-1:0] got,
                              input logic [lsu_pkg::XLEN-1:0] exp, input int idx);
        checks++;
        if (got !== exp) begin
            $display("FAILED at %0t: access %0d wb_data %08h, expected %08h",
                     $time, idx, got, exp);
            data_errors++;
        end
    endtask

    task automatic check_itag(input logic [lsu_pkg::ITAG_WIDTH-1:0] got,
                              input logic [lsu_pkg::ITAG_WIDTH-1:0] exp, input int idx);
        checks++;
        if (got !== exp) begin
            $display("FAILED at %0t: access %0d wb_itag %0d, expected %0d",
                     $time, idx, got, exp);
            itag_errors++;
        end
    endtask

    task automatic check_err(input logic got, input logic exp, input int idx);
        checks++;
        if (got !== exp) begin
            $display("FAILED at %0t: access %0d wb_err %0b, expected %0b",
                     $time, idx, got, exp);
            err_errors++;
        end
    endtask

    // ======================================================================
    // Issue and write-back sides
    // ======================================================================

    // Back-to-back issue, payload held until issue_ready
    task automatic issue_all();
        int waited;
        for (int i = 0; i < stim_op.size(); i++) begin
            @(negedge clk);
            issue_valid  = 1'b1;
            issue_op     = stim_op[i];
            issue_base   = stim_base[i];
            issue_offset = stim_offset[i];
            issue_wdata  = stim_wdata[i];
            issue_itag   = stim_itag[i];
            waited = 0;
            #(SAMPLE_DLY);
            while (!issue_ready && waited < WAIT_LIMIT && !timed_out) begin
                @(negedge clk);
                #(SAMPLE_DLY);
                waited++;
            end
            if (!issue_ready) begin
                if (!timed_out) begin
                    $display("Timed out waiting for issue_ready on access %0d", i);
                    other_errors++;
                    timed_out = 1'b1;
                end
                break;
            end
            // Transfer completes at the coming rising edge
            exp_idx_q.push_back(i);
            exp_data_q.push_back(stim_exp_data[i]);
            exp_itag_q.push_back(stim_itag[i]);
            exp_err_q.push_back(stim_exp_err[i]);
        end
        @(negedge clk);
        issue_valid = 1'b0;
    endtask

    // Random wb_ready, low about one cycle in four
    task automatic collect_writebacks(input int total);
        int   waited;
        logic got;
        for (int k = 0; k < total; k++) begin
            waited = 0;
            got    = 1'b0;
            while (!got && waited < WAIT_LIMIT && !timed_out) begin
                @(negedge clk);
                lcg_state = lcg_next(lcg_state);
                wb_ready  = (lcg_state[31:30] != 2'b00);
                #(SAMPLE_DLY);
                got = wb_valid && wb_ready;
                waited++;
            end
            if (!got) begin
                if (!timed_out) begin
                    $display("Timed out waiting for write-back %0d", k);
                    other_errors++;
                    timed_out = 1'b1;
                end
                break;
            end
            if (exp_idx_q.size() == 0) begin
                $display("Write-back arrived with no access outstanding");
                other_errors++;
            end else begin
                check_data(wb_data, exp_data_q.pop_front(), exp_idx_q[0]);
                check_itag(wb_itag, exp_itag_q.pop_front(), exp_idx_q[0]);
                check_err(wb_err, exp_err_q.pop_front(), exp_idx_q[0]);
                void'(exp_idx_q.pop_front());
            end
        end
    endtask

    // Nothing extra after the last write-back, nothing left behind
    task automatic check_idle();
        @(negedge clk);
        wb_ready = 1'b1;
        repeat (4) begin
            #(SAMPLE_DLY);
            if (wb_valid) begin
                $display("Extra write-back seen after all accesses completed");
                other_errors++;
            end
            @(negedge clk);
        end
        if (exp_idx_q.size() != 0) begin
            $display("%0d accesses never wrote back", exp_idx_q.size());
            other_errors++;
        end
    endtask

    // ======================================================================
    // Main sequence
    // ======================================================================

    initial begin
        rst          = 1'b1;
        issue_valid  = 1'b0;
        issue_op     = lsu_pkg::LB;
        issue_base   = '0;
        issue_offset = '0;
        issue_wdata  = '0;
        issue_itag   = '0;
        wb_ready     = 1'b0;
        checks       = 0;
        data_errors  = 0;
        itag_errors  = 0;
        err_errors   = 0;
        other_errors = 0;
        timed_out    = 1'b0;
        lcg_state    = 32'hc6e6_7966;
        load_stimulus();

        // Two rising edges in reset
        repeat (2) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;
        #(SAMPLE_DLY);
        if (!issue_ready || wb_valid) begin
            $display("Wrong handshake levels after reset");
            other_errors++;
        end

        if (stim_op.size() > 0) begin
            fork
                issue_all();
                collect_writebacks(stim_op.size());
            join
            check_idle();
        end else begin
            $display("No accesses found in the stimulus file");
            other_errors++;
        end

        $display("checks=%0d data_errors=%0d itag_errors=%0d err_errors=%0d other_errors=%0d",
                 checks, data_errors, itag_errors, err_errors, other_errors);
        if (data_errors + itag_errors + err_errors + other_errors == 0) begin
            $display("=== PASS ===");
        end else begin
            $display("=== FAIL ===");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- all.f
hdl/lsu_pkg.sv
hdl/lsu_ifc.sv
hdl/agu.sv
hdl/lsu_ctrl.sv
hdl/dtcm.sv
hdl/lsu_top.sv
bench/tb_clock.sv
bench/tb_lsu.sv

//--- Bender.yml
package:
  name: lsu

sources:
  # Design, in compile order
  - hdl/lsu_pkg.sv
  - hdl/lsu_ifc.sv
  - hdl/agu.sv
  - hdl/lsu_ctrl.sv
  - hdl/dtcm.sv
  - hdl/lsu_top.sv
  # Testbench
  - target: simulation
    files:
      - bench/tb_clock.sv
      - bench/tb_lsu.sv

//--- bench/lsu_stimulus.txt
# op  base      offset wdata    itag exp_wb_data exp_wb_err  (all but op in hex)
# expected values assume the data memory starts cleared
SW  00000100 000 deadbeef 0 00000000 0
LW  00000100 000 00000000 1 deadbeef 0
SW  00000200 000 11223344 2 00000000 0
SB  00000200 001 000000aa 3 00000000 0
SH  00000200 002 0000bbcc 0 00000000 0
SB  00000200 000 ffffff55 1 00000000 0
LW  00000200 000 00000000 2 bbccaa55 0
SW  00000300 000 80f07f81 3 00000000 0
LB  00000300 000 00000000 0 ffffff81 0
LBU 00000300 000 00000000 1 00000081 0
LB  00000300 001 00000000 2 0000007f 0
LH  00000300 002 00000000 3 ffff80f0 0
LHU 00000300 002 00000000 0 000080f0 0
LH  00000300 000 00000000 1 00007f81 0
LB  00000300 003 00000000 2 ffffff80 0
LBU 00000300 002 00000000 3 000000f0 0
LH  00000300 001 00000000 0 00000000 1
SW  00000300 002 12345678 1 00000000 1
SH  00000303 000 0000ffff 2 00000000 1
LW  00000300 000 00000000 3 80f07f81 0
LW  00000100 003 00000000 0 00000000 1
SW  00000110 ff0 cafef00d 1 00000000 0
LW  000000f8 008 00000000 2 cafef00d 0
SW  00000400 004 a5a55a5a 3 00000000 0
LW  00000004 000 00000000 0 a5a55a5a 0
LW  00000804 000 00000000 1 a5a55a5a 0
LW  000003fc 008 00000000 2 a5a55a5a 0
SW  000003fc 000 9abc1234 3 00000000 0
LH  00000002 ffc 00000000 0 ffff9abc 0
LBU 00000000 7ff 00000000 1 0000009a 0
LB  00000805 800 00000000 2 0000005a 0
SB  00000010 000 00000099 3 00000000 0
LBU 00000010 000 00000000 0 00000099 0
LB  00000010 000 00000000 1 ffffff99 0
SH  00000012 000 0000fedc 2 00000000 0
LW  00000010 000 00000000 3 fedc0099 0
LHU 00000010 002 00000000 0 0000fedc 0
